// File: hw/mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// page geometry, Sv32 style 4 KiB pages
`define MMU_OFFSET_BITS 12
`define MMU_VPN_BITS 20
`define MMU_PPN_BITS 20

// derived address widths
`define MMU_VADDR_BITS (`MMU_VPN_BITS + `MMU_OFFSET_BITS)
`define MMU_PADDR_BITS (`MMU_PPN_BITS + `MMU_OFFSET_BITS)

// fully associative TLB, index width must cover the entry count
`define MMU_TLB_ENTRIES 4
`define MMU_TLB_INDEX_BITS 2

`endif

// File: hw/mmu_priv_pkg.sv
package mmu_priv_pkg;

    // RISC-V privilege encoding, value 2 is reserved
    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_level_t;

    // CSR fields that the translation path looks at
    typedef struct packed {
        // satp mode, 0 means bare (no translation)
        logic        satp_mode;
        priv_level_t current_privilege;
        // mstatus bits
        logic        mprv;
        logic        mxr;
        logic        sum;
        priv_level_t mpp;
    } csr_state_t;

endpackage

// File: hw/mmu_access_pkg.sv
package mmu_access_pkg;

    `include "mmu_defs.svh"

    // cache command codes
    typedef enum logic [3:0] {
        CMD_NONE    = 4'd0,
        CMD_LOAD    = 4'd1,
        CMD_STORE   = 4'd2,
        CMD_EXECUTE = 4'd3
    } cache_cmd_t;

    // Sv32 PTE flags, valid sits in bit 0 and dirty in bit 7
    typedef struct packed {
        logic dirty;
        logic access;
        logic global_page;
        logic user;
        logic execute;
        logic write;
        logic read;
        logic valid;
    } access_tag_t;

    // request into the lookup stage
    typedef struct packed {
        cache_cmd_t                  cmd;
        logic [`MMU_VADDR_BITS-1:0]  vaddr;
    } mmu_req_t;

    // payload between lookup and check stages
    typedef struct packed {
        cache_cmd_t                  cmd;
        logic [`MMU_PADDR_BITS-1:0]  paddr;
        access_tag_t                 tag;
        logic                        hit;
    } mmu_lookup_t;

    // translated response
    typedef struct packed {
        logic [`MMU_PADDR_BITS-1:0]  paddr;
        logic                        pagefault;
        logic                        miss;
    } mmu_rsp_t;

endpackage

// File: hw/mmu_tlb_lookup.sv
`timescale 1ns/1ps

`include "mmu_defs.svh"

module mmu_tlb_lookup (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              csr_satp_mode,

    input  logic                              req_valid,
    output logic                              req_ready,
    input  mmu_access_pkg::mmu_req_t          req,

    input  logic                              fill_valid,
    input  logic [`MMU_TLB_INDEX_BITS-1:0]    fill_index,
    input  logic [`MMU_VPN_BITS-1:0]          fill_vpn,
    input  logic [`MMU_PPN_BITS-1:0]          fill_ppn,
    input  mmu_access_pkg::access_tag_t       fill_tag,

    output logic                              lookup_valid,
    input  logic                              lookup_ready,
    output mmu_access_pkg::mmu_lookup_t       lookup
);

    localparam int ENTRIES = `MMU_TLB_ENTRIES;

    // TLB storage
    logic [`MMU_VPN_BITS-1:0]     tlb_vpn [ENTRIES];
    logic [`MMU_PPN_BITS-1:0]     tlb_ppn [ENTRIES];
    mmu_access_pkg::access_tag_t  tlb_tag [ENTRIES];
    logic [ENTRIES-1:0]           tlb_valid;

    // lookup signals
    logic [`MMU_VPN_BITS-1:0]     req_vpn;
    logic [`MMU_OFFSET_BITS-1:0]  req_offset;
    logic [ENTRIES-1:0]           match;
    logic [`MMU_PPN_BITS-1:0]     sel_ppn;
    mmu_access_pkg::access_tag_t  sel_tag;
    logic                         tlb_hit;
    mmu_access_pkg::mmu_lookup_t  lookup_next;
    logic                         accept;

    assign req_vpn    = req.vaddr[`MMU_OFFSET_BITS +: `MMU_VPN_BITS];
    assign req_offset = req.vaddr[`MMU_OFFSET_BITS-1:0];

    // entry valid bits are the only reset state of the TLB
    always_ff @(posedge clk) begin
        if (reset) begin
            tlb_valid <= '0;
        end else if (fill_valid) begin
            tlb_valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tlb_vpn[fill_index] <= fill_vpn;
            tlb_ppn[fill_index] <= fill_ppn;
            tlb_tag[fill_index] <= fill_tag;
        end
    end

    // compare against every entry in parallel
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            match[i] = tlb_valid[i] && (tlb_vpn[i] == req_vpn);
        end
    end

    assign tlb_hit = |match;

    // lowest matching index wins if the fill side ever left duplicates
    always_comb begin
        sel_ppn = '0;
        sel_tag = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_ppn = tlb_ppn[i];
                sel_tag = tlb_tag[i];
            end
        end
    end

    // form the stage output from the request and the selected entry
    always_comb begin
        lookup_next.cmd = req.cmd;
        if (!csr_satp_mode) begin
            // bare mode, address passes straight through
            lookup_next.paddr = req.vaddr;
            lookup_next.tag   = '0;
            lookup_next.hit   = 1'b1;
        end else if (tlb_hit) begin
            lookup_next.paddr = {sel_ppn, req_offset};
            lookup_next.tag   = sel_tag;
            lookup_next.hit   = 1'b1;
        end else begin
            lookup_next.paddr = '0;
            lookup_next.tag   = '0;
            lookup_next.hit   = 1'b0;
        end
    end

    // one register slot, refills in the same cycle it drains
    assign req_ready = !lookup_valid || lookup_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_valid <= 1'b0;
        end else if (req_ready) begin
            lookup_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lookup <= lookup_next;
        end
    end

endmodule

// File: hw/mmu_access_check.sv
`timescale 1ns/1ps

module mmu_access_check (
    input  logic                              clk,
    input  logic                              reset,

    input  mmu_priv_pkg::csr_state_t          csr,

    input  logic                              lookup_valid,
    output logic                              lookup_ready,
    input  mmu_access_pkg::mmu_lookup_t       lookup,

    output logic                              rsp_valid,
    input  logic                              rsp_ready,
    output mmu_access_pkg::mmu_rsp_t          rsp
);

    mmu_priv_pkg::priv_level_t    eff_priv;
    mmu_access_pkg::access_tag_t  tag;
    logic                         tag_ok;
    logic                         bypass;
    logic                         fault;
    mmu_access_pkg::mmu_rsp_t     rsp_next;
    logic                         accept;

    assign tag = lookup.tag;

    // mprv in machine mode makes loads and stores run at mpp
    assign eff_priv = ((csr.current_privilege == mmu_priv_pkg::PRIV_MACHINE) && csr.mprv) ?
                      csr.mpp : csr.current_privilege;

    // a leaf entry needs valid and at least read or execute
    assign tag_ok = tag.valid && (tag.read || tag.execute);

    assign bypass = (eff_priv == mmu_priv_pkg::PRIV_MACHINE) || !csr.satp_mode;

    always_comb begin
        fault = 1'b0;
        if (!bypass) begin
            if (!tag_ok) begin
                fault = 1'b1;
            end

            // privilege against the user bit
            if (eff_priv == mmu_priv_pkg::PRIV_SUPERVISOR) begin
                if (tag.user && !csr.sum) begin
                    fault = 1'b1;
                end
            end else if (eff_priv == mmu_priv_pkg::PRIV_USER) begin
                if (!tag.user) begin
                    fault = 1'b1;
                end
            end

            // command against the permission bits
            if (!tag.access) begin
                fault = 1'b1;
            end else if (lookup.cmd == mmu_access_pkg::CMD_STORE) begin
                if (!tag.dirty || !tag.write) begin
                    fault = 1'b1;
                end
            end else if (lookup.cmd == mmu_access_pkg::CMD_LOAD) begin
                // mxr lets loads read executable pages
                if (!tag.read && !(csr.mxr && tag.execute)) begin
                    fault = 1'b1;
                end
            end else if (lookup.cmd == mmu_access_pkg::CMD_EXECUTE) begin
                if (!tag.execute) begin
                    fault = 1'b1;
                end
            end
        end
    end

    // a miss is reported as such and never checked
    always_comb begin
        rsp_next.paddr     = lookup.paddr;
        rsp_next.miss      = !lookup.hit;
        rsp_next.pagefault = lookup.hit && fault;
    end

    assign lookup_ready = !rsp_valid || rsp_ready;
    assign accept       = lookup_valid && lookup_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (lookup_ready) begin
            rsp_valid <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp <= rsp_next;
        end
    end

endmodule

// File: hw/mmu_top.sv
`timescale 1ns/1ps

`include "mmu_defs.svh"

module mmu_top (
    input  logic                              clk,
    input  logic                              reset,

    input  mmu_priv_pkg::csr_state_t          csr,

    input  logic                              req_valid,
    output logic                              req_ready,
    input  mmu_access_pkg::mmu_req_t          req,

    input  logic                              fill_valid,
    input  logic [`MMU_TLB_INDEX_BITS-1:0]    fill_index,
    input  logic [`MMU_VPN_BITS-1:0]          fill_vpn,
    input  logic [`MMU_PPN_BITS-1:0]          fill_ppn,
    input  mmu_access_pkg::access_tag_t       fill_tag,

    output logic                              rsp_valid,
    input  logic                              rsp_ready,
    output mmu_access_pkg::mmu_rsp_t          rsp
);

    // stage one to stage two
    logic                         lookup_valid;
    logic                         lookup_ready;
    mmu_access_pkg::mmu_lookup_t  lookup;

    mmu_tlb_lookup u_lookup (
        .clk           (clk),
        .reset         (reset),
        .csr_satp_mode (csr.satp_mode),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .fill_valid    (fill_valid),
        .fill_index    (fill_index),
        .fill_vpn      (fill_vpn),
        .fill_ppn      (fill_ppn),
        .fill_tag      (fill_tag),
        .lookup_valid  (lookup_valid),
        .lookup_ready  (lookup_ready),
        .lookup        (lookup)
    );

    mmu_access_check u_check (
        .clk           (clk),
        .reset         (reset),
        .csr           (csr),
        .lookup_valid  (lookup_valid),
        .lookup_ready  (lookup_ready),
        .lookup        (lookup),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp)
    );

endmodule

// File: dv/mmu_asserts.sv
`timescale 1ns/1ps

module mmu_asserts (
    input logic                      clk,
    input logic                      reset,
    input logic                      req_ready,
    input logic                      rsp_valid,
    input logic                      rsp_ready,
    input mmu_access_pkg::mmu_rsp_t  rsp
);

    // a stalled response keeps its valid and its payload
    property rsp_held_under_stall;
        @(posedge clk) disable iff (reset)
            (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp));
    endproperty

    // a miss is never also a fault
    property fault_and_miss_exclusive;
        @(posedge clk) disable iff (reset)
            rsp_valid |-> !(rsp.pagefault && rsp.miss);
    endproperty

    // pipeline comes out of reset empty and ready
    property empty_after_reset;
        @(posedge clk)
            $fell(reset) |-> (!rsp_valid && req_ready);
    endproperty

    assert property (rsp_held_under_stall)
        else $error("response changed while stalled");

    assert property (fault_and_miss_exclusive)
        else $error("pagefault and miss both set");

    assert property (empty_after_reset)
        else $error("pipeline not empty after reset");

endmodule

bind mmu_top mmu_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
);

// File: dv/mmu_tb.sv
`timescale 1ns/1ps

`include "mmu_defs.svh"

module mmu_tb;

    localparam int NUM_ROWS       = 25;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 2 * 8 + 200;

    typedef struct packed {
        mmu_access_pkg::mmu_rsp_t  rsp;
        logic                      timed;
    } expect_t;

    logic                               clk;
    logic                               reset;
    mmu_priv_pkg::csr_state_t           csr;
    logic                               req_valid;
    logic                               req_ready;
    mmu_access_pkg::mmu_req_t           req;
    logic                               fill_valid;
    logic [`MMU_TLB_INDEX_BITS-1:0]     fill_index;
    logic [`MMU_VPN_BITS-1:0]           fill_vpn;
    logic [`MMU_PPN_BITS-1:0]           fill_ppn;
    mmu_access_pkg::access_tag_t        fill_tag;
    logic                               rsp_valid;
    logic                               rsp_ready;
    mmu_access_pkg::mmu_rsp_t           rsp;

    // stimulus table
    mmu_priv_pkg::csr_state_t     row_csr   [NUM_ROWS];
    mmu_access_pkg::cache_cmd_t   row_cmd   [NUM_ROWS];
    logic [31:0]                  row_vaddr [NUM_ROWS];
    logic                         row_pf    [NUM_ROWS];
    logic                         row_miss  [NUM_ROWS];
    logic [31:0]                  row_paddr [NUM_ROWS];
    int                           row_count = 0;

    expect_t  exp_q[$];
    int       accept_q[$];
    int       cycle = 0;
    int       rsp_count = 0;
    integer   seed = 21;
    logic     random_backpressure = 1'b0;

    mmu_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .csr        (csr),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .fill_valid (fill_valid),
        .fill_index (fill_index),
        .fill_vpn   (fill_vpn),
        .fill_ppn   (fill_ppn),
        .fill_tag   (fill_tag),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic mmu_priv_pkg::csr_state_t make_csr(
        input logic satp_mode, input mmu_priv_pkg::priv_level_t priv, input logic mprv,
        input logic mxr, input logic sum, input mmu_priv_pkg::priv_level_t mpp);
        mmu_priv_pkg::csr_state_t value;
        value.satp_mode         = satp_mode;
        value.current_privilege = priv;
        value.mprv              = mprv;
        value.mxr               = mxr;
        value.sum               = sum;
        value.mpp               = mpp;
        return value;
    endfunction

    task automatic add_row(input mmu_priv_pkg::csr_state_t row_state,
                           input mmu_access_pkg::cache_cmd_t cmd, input logic [31:0] vaddr,
                           input logic pf, input logic miss, input logic [31:0] paddr);
        row_csr[row_count]   = row_state;
        row_cmd[row_count]   = cmd;
        row_vaddr[row_count] = vaddr;
        row_pf[row_count]    = pf;
        row_miss[row_count]  = miss;
        row_paddr[row_count] = paddr;
        row_count++;
    endtask

    task automatic build_table;
        mmu_priv_pkg::csr_state_t bare;
        mmu_priv_pkg::csr_state_t mach;
        mmu_priv_pkg::csr_state_t usr;
        mmu_priv_pkg::csr_state_t sup;
        mmu_priv_pkg::csr_state_t sup_sum;
        mmu_priv_pkg::csr_state_t sup_mxr;
        mmu_priv_pkg::csr_state_t mprv_usr;
        mmu_priv_pkg::csr_state_t mprv_sup;
        bare     = make_csr(1'b0, mmu_priv_pkg::PRIV_SUPERVISOR, 1'b0, 1'b0, 1'b0,
                            mmu_priv_pkg::PRIV_USER);
        mach     = make_csr(1'b1, mmu_priv_pkg::PRIV_MACHINE, 1'b0, 1'b0, 1'b0,
                            mmu_priv_pkg::PRIV_USER);
        usr      = make_csr(1'b1, mmu_priv_pkg::PRIV_USER, 1'b0, 1'b0, 1'b0,
                            mmu_priv_pkg::PRIV_USER);
        sup      = make_csr(1'b1, mmu_priv_pkg::PRIV_SUPERVISOR, 1'b0, 1'b0, 1'b0,
                            mmu_priv_pkg::PRIV_USER);
        sup_sum  = make_csr(1'b1, mmu_priv_pkg::PRIV_SUPERVISOR, 1'b0, 1'b0, 1'b1,
                            mmu_priv_pkg::PRIV_USER);
        sup_mxr  = make_csr(1'b1, mmu_priv_pkg::PRIV_SUPERVISOR, 1'b0, 1'b1, 1'b0,
                            mmu_priv_pkg::PRIV_USER);
        mprv_usr = make_csr(1'b1, mmu_priv_pkg::PRIV_MACHINE, 1'b1, 1'b0, 1'b0,
                            mmu_priv_pkg::PRIV_USER);
        mprv_sup = make_csr(1'b1, mmu_priv_pkg::PRIV_MACHINE, 1'b1, 1'b0, 1'b0,
                            mmu_priv_pkg::PRIV_SUPERVISOR);
        // bare mode passes the address through whatever the tags say
        add_row(bare, mmu_access_pkg::CMD_LOAD,    32'h1234_5678, 1'b0, 1'b0, 32'h1234_5678);
        add_row(bare, mmu_access_pkg::CMD_STORE,   32'h0004_0ABC, 1'b0, 1'b0, 32'h0004_0ABC);
        add_row(bare, mmu_access_pkg::CMD_EXECUTE, 32'h0009_9000, 1'b0, 1'b0, 32'h0009_9000);
        // machine mode translates but never faults
        add_row(mach, mmu_access_pkg::CMD_STORE,   32'h0002_0004, 1'b0, 1'b0, 32'h8002_0004);
        add_row(mach, mmu_access_pkg::CMD_EXECUTE, 32'h0004_0010, 1'b0, 1'b0, 32'h8004_0010);
        add_row(mach, mmu_access_pkg::CMD_LOAD,    32'h0007_7000, 1'b0, 1'b1, 32'h0000_0000);
        // user mode
        add_row(usr, mmu_access_pkg::CMD_LOAD,     32'h0001_0123, 1'b0, 1'b0, 32'h8001_0123);
        add_row(usr, mmu_access_pkg::CMD_STORE,    32'h0001_0FFC, 1'b0, 1'b0, 32'h8001_0FFC);
        add_row(usr, mmu_access_pkg::CMD_LOAD,     32'h0005_0000, 1'b0, 1'b1, 32'h0000_0000);
        add_row(usr, mmu_access_pkg::CMD_LOAD,     32'h0002_0010, 1'b1, 1'b0, 32'h8002_0010);
        add_row(usr, mmu_access_pkg::CMD_LOAD,     32'h0004_0080, 1'b1, 1'b0, 32'h8004_0080);
        add_row(usr, mmu_access_pkg::CMD_EXECUTE,  32'h0004_0080, 1'b1, 1'b0, 32'h8004_0080);
        add_row(usr, mmu_access_pkg::CMD_STORE,    32'h0004_0080, 1'b1, 1'b0, 32'h8004_0080);
        // supervisor mode without sum or mxr
        add_row(sup, mmu_access_pkg::CMD_LOAD,     32'h0001_0010, 1'b1, 1'b0, 32'h8001_0010);
        add_row(sup, mmu_access_pkg::CMD_STORE,    32'h0002_0020, 1'b1, 1'b0, 32'h8002_0020);
        add_row(sup, mmu_access_pkg::CMD_LOAD,     32'h0002_0020, 1'b0, 1'b0, 32'h8002_0020);
        add_row(sup, mmu_access_pkg::CMD_LOAD,     32'h0003_0040, 1'b1, 1'b0, 32'h8003_0040);
        add_row(sup, mmu_access_pkg::CMD_EXECUTE,  32'h0003_0040, 1'b0, 1'b0, 32'h8003_0040);
        add_row(sup, mmu_access_pkg::CMD_EXECUTE,  32'h0002_0020, 1'b1, 1'b0, 32'h8002_0020);
        add_row(sup, mmu_access_pkg::CMD_LOAD,     32'h0009_9ABC, 1'b0, 1'b1, 32'h0000_0000);
        add_row(sup_sum, mmu_access_pkg::CMD_LOAD, 32'h0001_0010, 1'b0, 1'b0, 32'h8001_0010);
        add_row(sup_mxr, mmu_access_pkg::CMD_LOAD, 32'h0003_0040, 1'b0, 1'b0, 32'h8003_0040);
        // mprv takes mpp as the effective privilege
        add_row(mprv_usr, mmu_access_pkg::CMD_LOAD, 32'h0002_0010, 1'b1, 1'b0, 32'h8002_0010);
        add_row(mprv_usr, mmu_access_pkg::CMD_LOAD, 32'h0001_0010, 1'b0, 1'b0, 32'h8001_0010);
        add_row(mprv_sup, mmu_access_pkg::CMD_LOAD, 32'h0002_0010, 1'b0, 1'b0, 32'h8002_0010);
    endtask

    task automatic fill_entry(input logic [`MMU_TLB_INDEX_BITS-1:0] index,
                              input logic [`MMU_VPN_BITS-1:0] vpn,
                              input logic [`MMU_PPN_BITS-1:0] ppn,
                              input mmu_access_pkg::access_tag_t tag);
        fill_valid = 1'b1;
        fill_index = index;
        fill_vpn   = vpn;
        fill_ppn   = ppn;
        fill_tag   = tag;
        @(negedge clk);
        fill_valid = 1'b0;
    endtask

    // csr may only change while nothing is in flight
    task automatic wait_for_drain;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic send_row(input int idx, input logic timed);
        expect_t item;
        if (row_csr[idx] != csr) begin
            wait_for_drain();
            csr = row_csr[idx];
        end
        item.rsp.paddr     = row_paddr[idx];
        item.rsp.pagefault = row_pf[idx];
        item.rsp.miss      = row_miss[idx];
        item.timed         = timed;
        exp_q.push_back(item);
        req_valid = 1'b1;
        req.cmd   = row_cmd[idx];
        req.vaddr = row_vaddr[idx];
        do begin
            @(posedge clk);
        end while (!req_ready);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    initial begin : backpressure
        rsp_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (random_backpressure) begin
                rsp_ready = (($random(seed) & 3) != 0);
            end else begin
                rsp_ready = 1'b1;
            end
        end
    end

    // cycle count, timeout, acceptance times and response checks
    initial begin : monitor
        expect_t item;
        int      acc_cycle;
        forever begin
            @(posedge clk);
            cycle = cycle + 1;
            if (cycle > TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles with %0d responses still outstanding",
                         cycle, exp_q.size());
                $display("RESULT: FAIL");
                $fatal(1, "simulation timed out");
            end else begin
                if (!reset && req_valid && req_ready) begin
                    accept_q.push_back(cycle);
                end
                if (!reset && rsp_valid && rsp_ready) begin
                    if (exp_q.size() == 0 || accept_q.size() == 0) begin
                        $display("response at %0t with no request outstanding", $time);
                        $display("RESULT: FAIL");
                        $fatal(1, "unexpected response");
                    end else begin
                        item      = exp_q.pop_front();
                        acc_cycle = accept_q.pop_front();
                        check_value("rsp.paddr", rsp.paddr, item.rsp.paddr);
                        check_value("rsp.pagefault", 32'(rsp.pagefault),
                                    32'(item.rsp.pagefault));
                        check_value("rsp.miss", 32'(rsp.miss), 32'(item.rsp.miss));
                        if (item.timed) begin
                            check_value("rsp latency", 32'(cycle - acc_cycle), 32'd2);
                        end
                        rsp_count++;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        reset      = 1'b1;
        csr        = '0;
        req_valid  = 1'b0;
        req        = '0;
        fill_valid = 1'b0;
        fill_index = '0;
        fill_vpn   = '0;
        fill_ppn   = '0;
        fill_tag   = '0;
        build_table();
        check_value("table rows", 32'(row_count), 32'(NUM_ROWS));
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("req_ready", 32'(req_ready), 32'd1);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        // user page, supervisor read-only, execute-only, access and dirty clear
        fill_entry(2'd0, 20'h00010, 20'h80010, 8'hDF);
        fill_entry(2'd1, 20'h00020, 20'h80020, 8'h43);
        fill_entry(2'd2, 20'h00030, 20'h80030, 8'h49);
        fill_entry(2'd3, 20'h00040, 20'h80040, 8'h1F);
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_row(i, 1'b1);
        end
        wait_for_drain();
        @(posedge clk);
        random_backpressure = 1'b1;
        @(negedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_row(i, 1'b0);
        end
        wait_for_drain();
        // a stray response would show up during these idle cycles
        repeat (4) @(negedge clk);
        if (rsp_valid || !req_ready) begin
            $display("pipeline not idle after %0d responses", rsp_count);
            $display("RESULT: FAIL");
            $fatal(1, "pipeline not idle at end of test");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+hw
hw/mmu_priv_pkg.sv
hw/mmu_access_pkg.sv
hw/mmu_tlb_lookup.sv
hw/mmu_access_check.sv
hw/mmu_top.sv
dv/mmu_asserts.sv
dv/mmu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module mmu_tb -o mmu_sim &&
out="$(./obj_dir/mmu_sim 2>&1)"
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
